/* hw/gb_cart_pkg.sv */
/*
 * Cartridge MBC shared definitions.
 * Bus widths, header offsets, CPU region codes and the controller kind.
 */
`default_nettype none

package gb_cart_pkg;

	// --------------------------------------------------
	// bus and memory widths
	// --------------------------------------------------
	typedef logic [15:0] cpu_addr_t;   // CPU bus address
	typedef logic [7:0]  byte_t;       // CPU data byte
	typedef logic [15:0] word_t;       // download and ROM memory word
	typedef logic [24:0] dl_addr_t;    // download byte address
	typedef logic [22:0] rom_waddr_t;  // ROM memory word address
	typedef logic [8:0]  rom_bank_t;   // 16 KB bank number or ROM mask
	typedef logic [3:0]  ram_bank_t;   // 8 KB bank number or RAM mask
	typedef logic [16:0] cram_addr_t;  // cartridge RAM byte address

	// decoded controller kind
	typedef enum logic [2:0] {
		MBC_NONE = 3'd0,
		MBC_1    = 3'd1,
		MBC_2    = 3'd2,
		MBC_3    = 3'd3,
		MBC_5    = 3'd4
	} mbc_kind_t;

	// --------------------------------------------------
	// cartridge header, byte offsets into the image
	// --------------------------------------------------
	localparam dl_addr_t HDR_CGB_FLAG = 25'h000143;
	localparam dl_addr_t HDR_TYPE     = 25'h000147;
	localparam dl_addr_t HDR_ROM_SIZE = 25'h000148;
	localparam dl_addr_t HDR_RAM_SIZE = 25'h000149;
	localparam dl_addr_t HDR_LICENSEE = 25'h00014B;

	// logo words, first and last word address
	localparam dl_addr_t LOGO_FIRST        = 25'h000104;
	localparam dl_addr_t LOGO_LAST         = 25'h000112;
	localparam dl_addr_t LOGO_BANK4_OFFSET = 25'h040000;  // second 256 KB game

	// CPU address bits 15:13
	localparam logic [2:0] REG_RAM_EN   = 3'b000;  // 0x0000-0x1FFF
	localparam logic [2:0] REG_ROM_BANK = 3'b001;  // 0x2000-0x3FFF
	localparam logic [2:0] REG_RAM_BANK = 3'b010;  // 0x4000-0x5FFF
	localparam logic [2:0] REG_MODE     = 3'b011;  // 0x6000-0x7FFF
	localparam logic [2:0] REG_CRAM     = 3'b101;  // 0xA000-0xBFFF

	localparam logic [3:0] RAM_ENABLE_KEY = 4'hA;
	localparam int         CRAM_DEPTH     = 131072;  // 16 banks of 8 KB

endpackage

`default_nettype wire

/* hw/cart_header_snoop.sv */
/*
 * Cartridge header snoop.
 * Watches the ROM download, keeps the header bytes and decodes the
 * controller kind, bank masks, flags and the MBC1 multicart variant.
 */
`timescale 1ns/1ps
`default_nettype none

module cart_header_snoop (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   dl_active,
	input  logic                   dl_wr,
	input  gb_cart_pkg::dl_addr_t  dl_addr,
	input  gb_cart_pkg::word_t     dl_data,
	output gb_cart_pkg::mbc_kind_t cart_kind,
	output gb_cart_pkg::rom_bank_t rom_mask,
	output gb_cart_pkg::ram_bank_t ram_mask,
	output logic                   mbc1m,
	output logic                   cart_battery,
	output logic                   cart_cgb
);
	import gb_cart_pkg::*;

	// the word that carries a header byte sits on the even address
	function automatic logic hdr_hit(dl_addr_t a, dl_addr_t ofs);
		return a == {ofs[24:1], 1'b0};
	endfunction

	function automatic byte_t hdr_byte(dl_addr_t ofs, word_t w);
		return ofs[0] ? w[15:8] : w[7:0];  // little endian words
	endfunction

	logic       dl_active_q;
	logic       dl_start;
	byte_t      cart_type;
	byte_t      cart_rom_size;
	byte_t      cart_ram_size;
	byte_t      cart_cgb_flag;
	word_t      logo_data [8];
	logic [7:0] logo_match;
	dl_addr_t   logo_ofs;
	logic [2:0] logo_idx;
	logic       in_logo;
	logic       in_copy;

	assign dl_start = dl_active & ~dl_active_q;
	assign logo_ofs = dl_addr - LOGO_FIRST;
	assign logo_idx = logo_ofs[3:1];  // same index in both windows
	assign in_logo  = (dl_addr >= LOGO_FIRST) && (dl_addr <= LOGO_LAST);
	assign in_copy  = (dl_addr >= LOGO_FIRST + LOGO_BANK4_OFFSET) &&
		(dl_addr <= LOGO_LAST + LOGO_BANK4_OFFSET);

	always_ff @(posedge clk_sys) begin
		if (reset)
			dl_active_q <= 1'b0;
		else
			dl_active_q <= dl_active;
	end

	// --------------------------------------------------
	// capture while the image streams in
	// --------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (dl_start) begin  // new image, forget the old header
			cart_type     <= '0;
			cart_rom_size <= '0;
			cart_ram_size <= '0;
			cart_cgb_flag <= '0;
			logo_match    <= '0;
		end
		if (dl_active && dl_wr) begin
			if (hdr_hit(dl_addr, HDR_CGB_FLAG))
				cart_cgb_flag <= hdr_byte(HDR_CGB_FLAG, dl_data);
			if (hdr_hit(dl_addr, HDR_TYPE))
				cart_type <= hdr_byte(HDR_TYPE, dl_data);
			if (hdr_hit(dl_addr, HDR_ROM_SIZE))
				cart_rom_size <= hdr_byte(HDR_ROM_SIZE, dl_data);
			if (hdr_hit(dl_addr, HDR_RAM_SIZE))
				cart_ram_size <= hdr_byte(HDR_RAM_SIZE, dl_data);
			if (in_logo)
				logo_data[logo_idx] <= dl_data;
			if (in_copy)  // multicarts repeat the logo for each game
				logo_match[logo_idx] <= (dl_data == logo_data[logo_idx]);
		end
	end

	// --------------------------------------------------
	// decode
	// --------------------------------------------------
	always_comb begin
		case (cart_type) inside
			[8'h01:8'h03]: cart_kind = MBC_1;
			[8'h05:8'h06]: cart_kind = MBC_2;
			[8'h0F:8'h13]: cart_kind = MBC_3;
			[8'h19:8'h1E]: cart_kind = MBC_5;
			default:       cart_kind = MBC_NONE;  // plain ROM, ROM+RAM
		endcase

		case (cart_type) inside
			8'h03, 8'h06, 8'h09, 8'h0D, 8'h0F, 8'h10, 8'h13,
			8'h1B, 8'h1E, 8'h22, 8'hFF: cart_battery = 1'b1;
			default:                    cart_battery = 1'b0;
		endcase

		if (cart_rom_size <= 8'd8)  // 2 << n banks
			rom_mask = 9'h1FF >> (4'd8 - cart_rom_size[3:0]);
		else
			rom_mask = 9'h07F;  // 72, 80 and 96 bank parts

		case (cart_ram_size)
			8'h00, 8'h01, 8'h02: ram_mask = 4'h0;  // at most one bank
			8'h03:               ram_mask = 4'h3;
			default:             ram_mask = 4'hF;
		endcase
	end

	assign cart_cgb = (cart_cgb_flag == 8'h80) || (cart_cgb_flag == 8'hC0);
	assign mbc1m    = &logo_match;

endmodule

`default_nettype wire

/* hw/mbc_bank_regs.sv */
/*
 * MBC bank registers.
 * Decodes CPU writes to 0x0000-0x7FFF into ROM bank, RAM bank,
 * MBC1 mode and RAM enable, per controller kind.
 */
`timescale 1ns/1ps
`default_nettype none

module mbc_bank_regs (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  gb_cart_pkg::cpu_addr_t cpu_addr,
	input  logic                   cpu_wr,
	input  gb_cart_pkg::byte_t     cpu_din,
	input  gb_cart_pkg::mbc_kind_t cart_kind,
	output gb_cart_pkg::rom_bank_t rom_bank,
	output gb_cart_pkg::ram_bank_t ram_bank,
	output logic                   mbc1_mode,
	output logic                   ram_enable
);
	import gb_cart_pkg::*;

	logic [2:0] region;
	logic       reg_wr;
	logic       is_mbc3;
	logic       is_mbc5;

	assign region  = cpu_addr[15:13];
	assign reg_wr  = cpu_wr & ~cpu_addr[15];  // register space is the ROM range
	assign is_mbc3 = (cart_kind == MBC_3);
	assign is_mbc5 = (cart_kind == MBC_5);

	// --------------------------------------------------
	// register writes
	// --------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_bank   <= 9'd1;
			ram_bank   <= 4'd0;
			mbc1_mode  <= 1'b0;
			ram_enable <= 1'b0;
		end else if (reg_wr) begin
			case (region)
				REG_RAM_EN: begin
					ram_enable <= (cpu_din[3:0] == RAM_ENABLE_KEY);
				end

				REG_ROM_BANK: begin
					if (is_mbc5) begin
						if (cpu_addr[12])  // 0x3000-0x3FFF carries bit 8
							rom_bank[8] <= cpu_din[0];
						else
							rom_bank[7:0] <= cpu_din;
					end else if (cpu_din[6:0] == 7'd0) begin
						rom_bank <= 9'd1;  // bank 0 is never selected here
					end else begin
						rom_bank <= {2'b00, cpu_din[6:0]};
					end
				end

				REG_RAM_BANK: begin
					if (is_mbc5)
						ram_bank <= cpu_din[3:0];
					else if (!(is_mbc3 && cpu_din[3]))  // bit 3 picks the clock
						ram_bank <= {2'b00, cpu_din[1:0]};
				end

				REG_MODE: begin
					if (cart_kind == MBC_1)
						mbc1_mode <= cpu_din[0];
				end

				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/mbc_addr_map.sv */
/*
 * MBC address mapping.
 * Turns a CPU access into a ROM word address or a cartridge RAM address.
 */
`timescale 1ns/1ps
`default_nettype none

module mbc_addr_map (
	input  gb_cart_pkg::cpu_addr_t  cpu_addr,
	input  logic                    cpu_rd,
	input  logic                    cpu_wr,
	input  gb_cart_pkg::mbc_kind_t  cart_kind,
	input  gb_cart_pkg::rom_bank_t  rom_mask,
	input  gb_cart_pkg::ram_bank_t  ram_mask,
	input  logic                    mbc1m,
	input  logic                    mbc1_mode,
	input  gb_cart_pkg::rom_bank_t  rom_bank,
	input  gb_cart_pkg::ram_bank_t  ram_bank,
	output logic                    rom_rd,
	output gb_cart_pkg::rom_waddr_t rom_raddr,
	output logic                    cram_rd,
	output logic                    cram_wr,
	output gb_cart_pkg::cram_addr_t cram_addr
);
	import gb_cart_pkg::*;

	logic       is_cram;
	logic [1:0] bank2;
	rom_bank_t  rom_sel;
	rom_bank_t  rom_eff;
	ram_bank_t  ram_sel;

	assign is_cram = (cpu_addr[15:13] == REG_CRAM);
	assign rom_rd  = cpu_rd & ~cpu_addr[15];
	assign cram_rd = cpu_rd & is_cram;
	assign cram_wr = cpu_wr & is_cram;

	// MBC1 upper bits, only reach the low half and RAM in mode 1
	assign bank2   = ram_bank[1:0] & {2{cpu_addr[14] | mbc1_mode}};
	assign rom_sel = cpu_addr[14] ? rom_bank : '0;  // 0x0000-0x3FFF is bank 0

	// --------------------------------------------------
	// ROM bank
	// --------------------------------------------------
	always_comb begin
		case (cart_kind)
			MBC_1: begin
				if (mbc1m)
					rom_eff = {3'b000, bank2, rom_sel[3:0]};
				else
					rom_eff = {2'b00, bank2, rom_sel[4:0]};
			end
			MBC_2, MBC_3, MBC_5: rom_eff = rom_sel;
			default:             rom_eff = {8'd0, cpu_addr[14]};  // flat 32 KB
		endcase
		rom_eff = rom_eff & rom_mask;  // mirror past the end of the image
	end

	assign rom_raddr = {1'b0, rom_eff, cpu_addr[13:1]};

	// --------------------------------------------------
	// RAM bank
	// --------------------------------------------------
	always_comb begin
		case (cart_kind)
			MBC_1:        ram_sel = {2'b00, bank2} & ram_mask;
			MBC_3, MBC_5: ram_sel = ram_bank & ram_mask;
			default:      ram_sel = '0;  // MBC2 and plain carts have one bank
		endcase
	end

	assign cram_addr = {ram_sel, cpu_addr[12:0]};

endmodule

`default_nettype wire

/* hw/cart_ram_data.sv */
/*
 * Cartridge RAM and CPU read return.
 * Holds the 128 KB save RAM and builds the read byte one cycle later.
 */
`timescale 1ns/1ps
`default_nettype none

module cart_ram_data (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    cram_rd,
	input  logic                    cram_wr,
	input  gb_cart_pkg::cram_addr_t cram_addr,
	input  gb_cart_pkg::byte_t      cpu_din,
	input  logic                    cpu_addr0,
	input  logic                    rom_rd,
	input  logic                    ram_enable,
	input  logic                    is_mbc2,
	input  gb_cart_pkg::word_t      rom_rdata,
	output gb_cart_pkg::byte_t      cpu_dout,
	output logic                    cpu_rvalid
);
	import gb_cart_pkg::*;

	byte_t cram [CRAM_DEPTH];
	byte_t ram_q;
	logic  src_ram_q;  // read came from cart RAM
	logic  addr0_q;
	logic  en_q;

	always_ff @(posedge clk_sys) begin
		if (cram_wr && ram_enable)
			cram[cram_addr] <= cpu_din;
		if (cram_rd)
			ram_q <= cram[cram_addr];
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cpu_rvalid <= 1'b0;
			src_ram_q  <= 1'b0;
			addr0_q    <= 1'b0;
			en_q       <= 1'b0;
		end else begin
			cpu_rvalid <= cram_rd | rom_rd;
			if (cram_rd | rom_rd) begin
				src_ram_q <= cram_rd;
				addr0_q   <= cpu_addr0;
				en_q      <= ram_enable;
			end
		end
	end

	// rom_rdata lands in the same cycle as cpu_rvalid
	always_comb begin
		if (!src_ram_q)
			cpu_dout = addr0_q ? rom_rdata[15:8] : rom_rdata[7:0];
		else if (!en_q)
			cpu_dout = 8'hFF;  // open bus
		else if (is_mbc2)
			cpu_dout = {4'hF, ram_q[3:0]};  // 4 bit wide RAM
		else
			cpu_dout = ram_q;
	end

endmodule

`default_nettype wire

/* hw/gb_cart_top.sv */
/*
 * Cartridge MBC top level.
 * Joins the image download, the CPU bus and the external ROM memory.
 */
`timescale 1ns/1ps
`default_nettype none

module gb_cart_top (
	input  logic                    clk_sys,
	input  logic                    reset,
	// image download
	input  logic                    dl_active,
	input  logic                    dl_wr,
	input  gb_cart_pkg::dl_addr_t   dl_addr,
	input  gb_cart_pkg::word_t      dl_data,
	// CPU bus
	input  gb_cart_pkg::cpu_addr_t  cpu_addr,
	input  logic                    cpu_rd,
	input  logic                    cpu_wr,
	input  gb_cart_pkg::byte_t      cpu_din,
	output gb_cart_pkg::byte_t      cpu_dout,
	output logic                    cpu_rvalid,
	// ROM memory
	output logic                    rom_rd,
	output gb_cart_pkg::rom_waddr_t rom_addr,
	output logic                    rom_wr,
	output gb_cart_pkg::word_t      rom_wdata,
	input  gb_cart_pkg::word_t      rom_rdata,
	output logic                    cart_battery,
	output logic                    cart_cgb
);
	import gb_cart_pkg::*;

	mbc_kind_t  cart_kind;
	rom_bank_t  rom_mask;
	ram_bank_t  ram_mask;
	logic       mbc1m;
	rom_bank_t  rom_bank;
	ram_bank_t  ram_bank;
	logic       mbc1_mode;
	logic       ram_enable;
	logic       map_rom_rd;
	rom_waddr_t map_rom_addr;
	logic       cram_rd;
	logic       cram_wr;
	cram_addr_t cram_addr;
	logic       bank_reset;
	logic       is_mbc2;

	assign bank_reset = reset | dl_active;  // banks restart with every image
	assign is_mbc2    = (cart_kind == MBC_2);

	// --------------------------------------------------
	// ROM memory port, download owns it while active
	// --------------------------------------------------
	assign rom_wr    = dl_active & dl_wr;
	assign rom_addr  = dl_active ? dl_addr[23:1] : map_rom_addr;
	assign rom_wdata = dl_data;
	assign rom_rd    = map_rom_rd & ~dl_active;

	cart_header_snoop u_snoop (
		.clk_sys(clk_sys), .reset(reset),
		.dl_active(dl_active), .dl_wr(dl_wr), .dl_addr(dl_addr), .dl_data(dl_data),
		.cart_kind(cart_kind), .rom_mask(rom_mask), .ram_mask(ram_mask),
		.mbc1m(mbc1m), .cart_battery(cart_battery), .cart_cgb(cart_cgb)
	);

	mbc_bank_regs u_regs (
		.clk_sys(clk_sys), .reset(bank_reset),
		.cpu_addr(cpu_addr), .cpu_wr(cpu_wr), .cpu_din(cpu_din), .cart_kind(cart_kind),
		.rom_bank(rom_bank), .ram_bank(ram_bank),
		.mbc1_mode(mbc1_mode), .ram_enable(ram_enable)
	);

	mbc_addr_map u_map (
		.cpu_addr(cpu_addr), .cpu_rd(cpu_rd), .cpu_wr(cpu_wr), .cart_kind(cart_kind),
		.rom_mask(rom_mask), .ram_mask(ram_mask), .mbc1m(mbc1m), .mbc1_mode(mbc1_mode),
		.rom_bank(rom_bank), .ram_bank(ram_bank),
		.rom_rd(map_rom_rd), .rom_raddr(map_rom_addr),
		.cram_rd(cram_rd), .cram_wr(cram_wr), .cram_addr(cram_addr)
	);

	cart_ram_data u_ram (
		.clk_sys(clk_sys), .reset(reset),
		.cram_rd(cram_rd), .cram_wr(cram_wr), .cram_addr(cram_addr), .cpu_din(cpu_din),
		.cpu_addr0(cpu_addr[0]), .rom_rd(rom_rd), .ram_enable(ram_enable),
		.is_mbc2(is_mbc2), .rom_rdata(rom_rdata),
		.cpu_dout(cpu_dout), .cpu_rvalid(cpu_rvalid)
	);

endmodule

`default_nettype wire

/* dv/gb_cart_checker.sv */
/*
 * Protocol assertions for the cartridge MBC top level.
 */
`timescale 1ns/1ps
`default_nettype none

module gb_cart_checker (
	input logic clk_sys,
	input logic reset,
	input logic dl_active,
	input logic dl_wr,
	input logic cpu_rd,
	input logic cpu_wr,
	input logic cpu_rvalid
);

	// read data comes back exactly one cycle later
	a_rvalid_after_rd: assert property (@(posedge clk_sys) disable iff (reset)
		cpu_rd |=> cpu_rvalid) else $error("cpu_rvalid missing after cpu_rd");
	a_no_stray_rvalid: assert property (@(posedge clk_sys) disable iff (reset)
		!cpu_rd |=> !cpu_rvalid) else $error("cpu_rvalid without a read");

	// image words only arrive inside a download
	a_dl_wr_in_dl: assert property (@(posedge clk_sys)
		dl_wr |-> dl_active) else $error("dl_wr outside download");

	a_no_cpu_in_dl: assert property (@(posedge clk_sys)
		dl_active |-> !(cpu_rd || cpu_wr)) else $error("CPU access during download");

	a_no_cpu_in_reset: assert property (@(posedge clk_sys)
		reset |-> !(cpu_rd || cpu_wr)) else $error("CPU access during reset");

endmodule

bind gb_cart_top gb_cart_checker i_checker (
	.clk_sys(clk_sys), .reset(reset), .dl_active(dl_active), .dl_wr(dl_wr),
	.cpu_rd(cpu_rd), .cpu_wr(cpu_wr), .cpu_rvalid(cpu_rvalid)
);

`default_nettype wire

/* dv/tb_gb_cart.sv */
/*
 * Testbench for the cartridge MBC top level.
 * ROM memory model, image download and a table of CPU steps with checks.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_gb_cart;
	import gb_cart_pkg::*;

	localparam int DL_WORDS = 'h20090;  // covers header and the 256 KB logo copy
	localparam logic [2:0] K_IMAGE = 3'd0;
	localparam logic [2:0] K_FLAGS = 3'd1;
	localparam logic [2:0] K_WRITE = 3'd2;
	localparam logic [2:0] K_READ  = 3'd3;
	localparam logic [2:0] K_BANK  = 3'd4;  // ROM read, exp holds the bank

	typedef struct packed {
		logic [2:0]  kind;
		logic [31:0] addr;
		logic [7:0]  data;
		logic [15:0] exp;
	} entry_t;

	logic       clk_sys = 1'b0;
	logic       reset;
	logic       dl_active;
	logic       dl_wr;
	dl_addr_t   dl_addr;
	word_t      dl_data;
	cpu_addr_t  cpu_addr;
	logic       cpu_rd;
	logic       cpu_wr;
	byte_t      cpu_din;
	byte_t      cpu_dout;
	logic       cpu_rvalid;
	logic       rom_rd;
	rom_waddr_t rom_addr;
	logic       rom_wr;
	word_t      rom_wdata;
	word_t      rom_rdata = '0;
	logic       cart_battery;
	logic       cart_cgb;

	logic [15:0] rom_mem [0:(1 << 22) - 1];
	entry_t      tbl [$];
	logic        tbl_ready = 1'b0;
	int          err_cnt = 0;
	byte_t       cur_type;
	byte_t       cur_rom;
	byte_t       cur_ram;
	byte_t       cur_cgb;
	logic        cur_copy;

	always #4 clk_sys = ~clk_sys;

	gb_cart_top i_dut (.*);

	// ROM memory, one cycle read latency
	always @(posedge clk_sys) begin
		if (rom_wr)
			rom_mem[rom_addr[21:0]] <= rom_wdata;
		if (rom_rd)
			rom_rdata <= rom_mem[rom_addr[21:0]];
	end

	// image byte at byte address b, with the header of the current image
	function automatic byte_t img_byte(logic [22:0] b);
		logic [22:0] src;
		byte_t       v;
		src = b;
		if (cur_copy && b >= 23'h40104 && b <= 23'h40113)
			src = b - 23'h40000;  // logo repeated for the second game
		v = src[7:0] ^ src[22:15] ^ {1'b0, src[14:8]};
		case (src)
			23'h143: v = cur_cgb;
			23'h147: v = cur_type;
			23'h148: v = cur_rom;
			23'h149: v = cur_ram;
			default: ;
		endcase
		return v;
	endfunction

	task automatic check(input logic [15:0] got, input logic [15:0] exp, input string what);
		if (got !== exp) begin
			err_cnt++;
			$display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	// --------------------------------------------------
	// stimulus table
	// --------------------------------------------------
	task automatic image_step(byte_t t, byte_t rs, byte_t ms, byte_t cgb, logic copy);
		tbl.push_back('{K_IMAGE, {cgb, t, rs, ms}, {7'd0, copy}, 16'd0});
	endtask

	task automatic flags_step(logic bat, logic cgb);
		tbl.push_back('{K_FLAGS, 32'd0, 8'd0, {14'd0, bat, cgb}});
	endtask

	task automatic write_step(logic [15:0] a, byte_t d);
		tbl.push_back('{K_WRITE, {16'd0, a}, d, 16'd0});
	endtask

	task automatic read_step(logic [15:0] a, byte_t e);
		tbl.push_back('{K_READ, {16'd0, a}, 8'd0, {8'd0, e}});
	endtask

	task automatic bank_step(logic [15:0] a, logic [8:0] bank);
		tbl.push_back('{K_BANK, {16'd0, a}, 8'd0, {7'd0, bank}});
	endtask

	task automatic build_table();
		// MBC1, 64 banks, 4 RAM banks
		image_step(8'h03, 8'h05, 8'h03, 8'h80, 1'b0);
		flags_step(1'b1, 1'b1);
		bank_step(16'h4000, 9'h001);
		write_step(16'h2000, 8'h00);
		bank_step(16'h4123, 9'h001);
		write_step(16'h2000, 8'h05);
		bank_step(16'h5ABD, 9'h005);
		write_step(16'h4000, 8'h01);
		bank_step(16'h7FFE, 9'h025);
		write_step(16'h4000, 8'h03);
		bank_step(16'h4001, 9'h025);  // 0x65 folds back into 64 banks
		bank_step(16'h0010, 9'h000);
		write_step(16'h6000, 8'h01);
		bank_step(16'h0011, 9'h020);
		read_step(16'hA000, 8'hFF);
		write_step(16'h0000, 8'h0A);
		write_step(16'hA000, 8'h11);
		write_step(16'h0000, 8'h03);
		read_step(16'hA000, 8'hFF);
		write_step(16'hA000, 8'h22);  // dropped, RAM is off
		write_step(16'h0000, 8'h0A);
		read_step(16'hA000, 8'h11);
		write_step(16'h4000, 8'h01);
		write_step(16'hA000, 8'h33);
		read_step(16'hA000, 8'h33);
		write_step(16'h4000, 8'h03);
		read_step(16'hA000, 8'h11);
		// MBC1M, then the same writes on a plain MBC1
		image_step(8'h01, 8'h05, 8'h00, 8'h00, 1'b1);
		flags_step(1'b0, 1'b0);
		write_step(16'h2000, 8'h15);
		write_step(16'h4000, 8'h02);
		bank_step(16'h4000, 9'h025);
		image_step(8'h01, 8'h05, 8'h00, 8'h00, 1'b0);
		write_step(16'h2000, 8'h15);
		write_step(16'h4000, 8'h02);
		bank_step(16'h4000, 9'h015);
		// MBC5, 512 banks, 16 RAM banks
		image_step(8'h1B, 8'h08, 8'h04, 8'h00, 1'b0);
		flags_step(1'b1, 1'b0);
		write_step(16'h2000, 8'hA7);
		bank_step(16'h4000, 9'h0A7);
		write_step(16'h3000, 8'h01);
		bank_step(16'h7FFF, 9'h1A7);
		write_step(16'h2000, 8'h00);
		bank_step(16'h4002, 9'h100);
		write_step(16'h3000, 8'h00);
		bank_step(16'h4003, 9'h000);
		write_step(16'h0000, 8'h0A);
		write_step(16'h4000, 8'h09);
		write_step(16'hA123, 8'h5C);
		write_step(16'h4000, 8'h02);
		write_step(16'hA123, 8'hC5);
		read_step(16'hA123, 8'hC5);
		write_step(16'h4000, 8'h09);
		read_step(16'hA123, 8'h5C);
		// MBC2 with its nibble RAM
		image_step(8'h06, 8'h03, 8'h00, 8'hC0, 1'b0);
		flags_step(1'b1, 1'b1);
		write_step(16'h0000, 8'h0A);
		write_step(16'hA010, 8'h37);
		read_step(16'hA010, 8'hF7);
		// plain 32 KB cartridge
		image_step(8'h00, 8'h00, 8'h00, 8'h00, 1'b0);
		flags_step(1'b0, 1'b0);
		bank_step(16'h0000, 9'h000);
		bank_step(16'h0147, 9'h000);
		bank_step(16'h4001, 9'h001);
		bank_step(16'h7FFF, 9'h001);
		write_step(16'h2000, 8'h03);
		bank_step(16'h4100, 9'h001);
	endtask

	// --------------------------------------------------
	// bus tasks
	// --------------------------------------------------
	task automatic download_image();
		@(posedge clk_sys);
		#1 dl_active = 1'b1;
		for (int w = 0; w < DL_WORDS; w++) begin
			@(posedge clk_sys);
			#1;
			dl_wr   = 1'b1;
			dl_addr = dl_addr_t'(2 * w);
			dl_data = {img_byte(23'(2 * w + 1)), img_byte(23'(2 * w))};
		end
		@(posedge clk_sys);
		#1 dl_wr = 1'b0;
		@(posedge clk_sys);
		#1 dl_active = 1'b0;
		@(posedge clk_sys);
		#1;
	endtask

	task automatic cpu_write(logic [15:0] a, byte_t d);
		@(posedge clk_sys);
		#1;
		cpu_addr = a;
		cpu_din  = d;
		cpu_wr   = 1'b1;
		@(posedge clk_sys);
		#1 cpu_wr = 1'b0;
	endtask

	task automatic cpu_read(logic [15:0] a, output byte_t d);
		@(posedge clk_sys);
		#1;
		cpu_addr = a;
		cpu_rd   = 1'b1;
		@(posedge clk_sys);
		#1;
		check({15'd0, cpu_rvalid}, 16'd1, "cpu_rvalid");
		d      = cpu_dout;
		cpu_rd = 1'b0;
	endtask

	initial begin : main
		byte_t  rd;
		entry_t e;
		reset = 1'b1;
		dl_active = 1'b0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		cpu_addr = '0;
		cpu_rd = 1'b0;
		cpu_wr = 1'b0;
		cpu_din = '0;
		{cur_type, cur_rom, cur_ram, cur_cgb, cur_copy} = '0;
		for (int i = 0; i < (1 << 22); i++)
			rom_mem[i] = {img_byte(23'(2 * i + 1)), img_byte(23'(2 * i))};
		build_table();
		tbl_ready = 1'b1;
		repeat (16) @(posedge clk_sys);
		#1 reset = 1'b0;
		foreach (tbl[i]) begin
			e = tbl[i];
			case (e.kind)
				K_IMAGE: begin
					{cur_cgb, cur_type, cur_rom, cur_ram} = e.addr;
					cur_copy = e.data[0];
					download_image();
				end
				K_FLAGS: check({14'd0, cart_battery, cart_cgb}, e.exp, "battery and cgb flags");
				K_WRITE: cpu_write(e.addr[15:0], e.data);
				K_READ: begin
					cpu_read(e.addr[15:0], rd);
					check({8'd0, rd}, e.exp, "RAM read");
				end
				default: begin
					cpu_read(e.addr[15:0], rd);
					check({8'd0, rd}, {8'd0, img_byte({e.exp[8:0], e.addr[13:0]})}, "ROM read");
				end
			endcase
		end
		if (err_cnt == 0) begin
			$display("No errors");
			$finish;
		end else begin
			$display("Errors found");
			$fatal(1);
		end
	end

	// watchdog sized from the table and the image length
	initial begin : watchdog
		int limit;
		int n_img;
		wait (tbl_ready);
		n_img = 0;
		foreach (tbl[i])
			if (tbl[i].kind == K_IMAGE)
				n_img++;
		limit = tbl.size() * 4 + n_img * (DL_WORDS + 8) + 116;
		repeat (limit) @(posedge clk_sys);
		$display("timeout: the test did not finish within %0d cycles", limit);
		$display("Errors found");
		$fatal(1);
	end

endmodule

`default_nettype wire

/* filelist.f */
hw/gb_cart_pkg.sv
hw/cart_header_snoop.sv
hw/mbc_bank_regs.sv
hw/mbc_addr_map.sv
hw/cart_ram_data.sv
hw/gb_cart_top.sv
dv/gb_cart_checker.sv
dv/tb_gb_cart.sv

/* Makefile */
# Verilator build and run for the cartridge MBC testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_gb_cart \
		-f filelist.f -o sim_gb_cart
	./obj_dir/sim_gb_cart > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "No errors" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)
